//--- logic/issue_pkg.sv
package issue_pkg;

    // Operations accepted at the dispatch port
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_LD  = 3'd4,
        OP_ST  = 3'd5
    } op_t;

    // Functional unit type served by a reservation station
    typedef enum logic {
        FU_IEU = 1'b0,
        FU_LSU = 1'b1
    } fu_type_t;

    // Every operation carries two source operands.
    // For loads and stores src0 is the address and src1 the store data
    localparam int N_SRC = 2;

endpackage

//--- logic/rr_picker.sv
`timescale 1ns/1ps

module rr_picker #(
    parameter int N = 3
)(
    input  logic         clk,
    input  logic         i_reset,
    input  logic         i_valid,
    input  logic [N-1:0] i_requests,
    output logic [N-1:0] o_grant
);

    localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] grant_idx;
    logic             found;

    // Search starts at the pointer and wraps around once
    always_comb begin
        int idx;
        o_grant   = '0;
        grant_idx = '0;
        found     = 1'b0;
        for (int i = 0; i < N; i++) begin
            idx = int'(ptr) + i;
            if (idx >= N) begin
                idx = idx - N;
            end
            if (!found && i_requests[idx]) begin
                found        = 1'b1;
                grant_idx    = PTR_W'(idx);
                o_grant[idx] = 1'b1;
            end
        end
    end

    // The pointer moves past the winner even if the request is not accepted downstream
    always_ff @(posedge clk) begin
        if (i_reset) begin
            ptr <= '0;
        end else if (i_valid && found) begin
            ptr <= (int'(grant_idx) == N - 1) ? '0 : grant_idx + 1'b1;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (i_reset)
        $onehot0(o_grant));
    a_grant_requested: assert property (@(posedge clk) disable iff (i_reset)
        (o_grant & ~i_requests) == '0);

endmodule

//--- logic/rs_switch.sv
`timescale 1ns/1ps

module rs_switch import issue_pkg::*; #(
    parameter int       DATA_WIDTH = 32,
    parameter int       TAG_WIDTH  = 5,
    parameter int       NUM_RS     = 3,
    parameter fu_type_t RS_FU_TYPES [NUM_RS] = '{default: FU_IEU}
)(
    input  logic                  clk,
    input  logic                  i_reset,

    input  logic                  i_cdb_en   [0:NUM_RS-1],
    input  logic [DATA_WIDTH-1:0] i_cdb_data [0:NUM_RS-1],
    input  logic [TAG_WIDTH-1:0]  i_cdb_tag  [0:NUM_RS-1],

    input  logic                  i_reserve_en,
    input  op_t                   i_reserve_op,

    input  logic                  i_src_rdy  [0:N_SRC-1],
    input  logic [DATA_WIDTH-1:0] i_src_data [0:N_SRC-1],
    input  logic [TAG_WIDTH-1:0]  i_src_tag  [0:N_SRC-1],

    input  logic [NUM_RS-1:0]     i_rs_stall,

    output logic [NUM_RS-1:0]     o_rs_reserve_en,
    output logic                  o_src_rdy  [0:N_SRC-1],
    output logic [DATA_WIDTH-1:0] o_src_data [0:N_SRC-1],
    output logic [TAG_WIDTH-1:0]  o_src_tag  [0:N_SRC-1],
    output logic                  o_stall
);

    fu_type_t          op_fu_type;
    logic [NUM_RS-1:0] rs_supported;
    logic [NUM_RS-1:0] rs_granted;

    // Loads and stores go to the LSU, everything else to an IEU
    assign op_fu_type = (i_reserve_op == OP_LD || i_reserve_op == OP_ST) ? FU_LSU : FU_IEU;

    always_comb begin
        for (int i = 0; i < NUM_RS; i++) begin
            rs_supported[i] = (RS_FU_TYPES[i] == op_fu_type);
        end
    end

    rr_picker #(
        .N (NUM_RS)
    ) u_rr_picker (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_valid    (i_reserve_en),
        .i_requests (rs_supported),
        .o_grant    (rs_granted)
    );

    // Only the granted station can hold up dispatch
    assign o_stall = |(rs_granted & i_rs_stall);

    // A stalled cycle writes nothing, so the station never sees a reserve while full
    assign o_rs_reserve_en = (i_reserve_en && !o_stall) ? rs_granted : '0;

    // Pick up results broadcast in the same cycle as the enqueue
    always_comb begin
        for (int s = 0; s < N_SRC; s++) begin
            o_src_rdy[s]  = i_src_rdy[s];
            o_src_data[s] = i_src_data[s];
            o_src_tag[s]  = i_src_tag[s];
            for (int c = 0; c < NUM_RS; c++) begin
                if (!i_src_rdy[s] && i_cdb_en[c] && (i_cdb_tag[c] == i_src_tag[s])) begin
                    o_src_rdy[s]  = 1'b1;
                    o_src_data[s] = i_cdb_data[c];
                end
            end
        end
    end

    a_reserve_onehot: assert property (@(posedge clk) disable iff (i_reset)
        $onehot0(o_rs_reserve_en));

endmodule

//--- logic/rsv_station.sv
`timescale 1ns/1ps

module rsv_station import issue_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int TAG_WIDTH  = 5,
    parameter int NUM_RS     = 3,
    parameter int RS_DEPTH   = 4
)(
    input  logic                  clk,
    input  logic                  i_reset,

    input  logic                  i_cdb_en   [0:NUM_RS-1],
    input  logic [DATA_WIDTH-1:0] i_cdb_data [0:NUM_RS-1],
    input  logic [TAG_WIDTH-1:0]  i_cdb_tag  [0:NUM_RS-1],

    input  logic                  i_reserve_en,
    input  op_t                   i_op,
    input  logic [TAG_WIDTH-1:0]  i_dst_tag,
    input  logic                  i_src_rdy  [0:N_SRC-1],
    input  logic [DATA_WIDTH-1:0] i_src_data [0:N_SRC-1],
    input  logic [TAG_WIDTH-1:0]  i_src_tag  [0:N_SRC-1],

    output logic                  o_full,
    output logic                  o_issue_en,
    output op_t                   o_issue_op,
    output logic [DATA_WIDTH-1:0] o_issue_src0,
    output logic [DATA_WIDTH-1:0] o_issue_src1,
    output logic [TAG_WIDTH-1:0]  o_issue_tag
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    logic [RS_DEPTH-1:0]   entry_valid;
    op_t                   entry_op      [0:RS_DEPTH-1];
    logic [TAG_WIDTH-1:0]  entry_dst_tag [0:RS_DEPTH-1];
    logic                  entry_rdy     [0:RS_DEPTH-1][0:N_SRC-1];
    logic [DATA_WIDTH-1:0] entry_data    [0:RS_DEPTH-1][0:N_SRC-1];
    logic [TAG_WIDTH-1:0]  entry_tag     [0:RS_DEPTH-1][0:N_SRC-1];

    logic [RS_DEPTH-1:0]   entry_ready;
    logic [IDX_W-1:0]      free_idx;
    logic [IDX_W-1:0]      issue_idx;
    logic                  issue_valid;

    // Scan downwards so the lowest index wins for both searches
    always_comb begin
        free_idx  = '0;
        issue_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            entry_ready[i] = entry_valid[i] && entry_rdy[i][0] && entry_rdy[i][1];
            if (!entry_valid[i]) begin
                free_idx = IDX_W'(i);
            end
            if (entry_ready[i]) begin
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign issue_valid = |entry_ready;
    assign o_full      = &entry_valid;

    // Issue and reserve never touch the same entry since one is valid and the other free
    always_ff @(posedge clk) begin
        if (i_reset) begin
            entry_valid <= '0;
        end else begin
            if (issue_valid) begin
                entry_valid[issue_idx] <= 1'b0;
            end
            if (i_reserve_en) begin
                entry_valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // Waiting sources snoop every CDB lane
        for (int e = 0; e < RS_DEPTH; e++) begin
            for (int s = 0; s < N_SRC; s++) begin
                for (int c = 0; c < NUM_RS; c++) begin
                    if (entry_valid[e] && !entry_rdy[e][s] && i_cdb_en[c] &&
                        (i_cdb_tag[c] == entry_tag[e][s])) begin
                        entry_rdy[e][s]  <= 1'b1;
                        entry_data[e][s] <= i_cdb_data[c];
                    end
                end
            end
        end
        if (i_reserve_en) begin
            entry_op[free_idx]      <= i_op;
            entry_dst_tag[free_idx] <= i_dst_tag;
            for (int s = 0; s < N_SRC; s++) begin
                entry_rdy[free_idx][s]  <= i_src_rdy[s];
                entry_data[free_idx][s] <= i_src_data[s];
                entry_tag[free_idx][s]  <= i_src_tag[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_issue_en <= 1'b0;
        end else begin
            o_issue_en <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            o_issue_op   <= entry_op[issue_idx];
            o_issue_src0 <= entry_data[issue_idx][0];
            o_issue_src1 <= entry_data[issue_idx][1];
            o_issue_tag  <= entry_dst_tag[issue_idx];
        end
    end

    // The switch must hold back dispatch when this station is full
    a_no_reserve_when_full: assert property (@(posedge clk) disable iff (i_reset)
        i_reserve_en |-> !o_full);

endmodule

//--- logic/ieu.sv
`timescale 1ns/1ps

module ieu import issue_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int TAG_WIDTH  = 5
)(
    input  logic                  clk,
    input  logic                  i_reset,

    input  logic                  i_issue_en,
    input  op_t                   i_op,
    input  logic [DATA_WIDTH-1:0] i_src0,
    input  logic [DATA_WIDTH-1:0] i_src1,
    input  logic [TAG_WIDTH-1:0]  i_tag,

    output logic                  o_cdb_en,
    output logic [DATA_WIDTH-1:0] o_cdb_data,
    output logic [TAG_WIDTH-1:0]  o_cdb_tag
);

    logic [DATA_WIDTH-1:0] alu_result;

    always_comb begin
        case (i_op)
            OP_ADD:  alu_result = i_src0 + i_src1;
            OP_SUB:  alu_result = i_src0 - i_src1;
            OP_AND:  alu_result = i_src0 & i_src1;
            OP_XOR:  alu_result = i_src0 ^ i_src1;
            default: alu_result = '0;
        endcase
    end

    // Result sits on this unit's lane for one cycle
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= i_issue_en;
        end
    end

    always_ff @(posedge clk) begin
        if (i_issue_en) begin
            o_cdb_data <= alu_result;
            o_cdb_tag  <= i_tag;
        end
    end

    // Loads and stores are routed to the LSU station, never here
    a_alu_op_only: assert property (@(posedge clk) disable iff (i_reset)
        i_issue_en |-> (i_op != OP_LD && i_op != OP_ST));

endmodule

//--- logic/lsu.sv
`timescale 1ns/1ps

module lsu import issue_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int TAG_WIDTH  = 5,
    parameter int MEM_WORDS  = 16
)(
    input  logic                  clk,
    input  logic                  i_reset,

    input  logic                  i_issue_en,
    input  op_t                   i_op,
    input  logic [DATA_WIDTH-1:0] i_src0,
    input  logic [DATA_WIDTH-1:0] i_src1,
    input  logic [TAG_WIDTH-1:0]  i_tag,

    output logic                  o_cdb_en,
    output logic [DATA_WIDTH-1:0] o_cdb_data,
    output logic [TAG_WIDTH-1:0]  o_cdb_tag
);

    localparam int ADDR_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [DATA_WIDTH-1:0] mem [0:MEM_WORDS-1];
    logic [ADDR_W-1:0]     addr;
    logic                  is_store;

    assign addr     = i_src0[ADDR_W-1:0];
    assign is_store = (i_op == OP_ST);

    // The data array starts out all zero so early loads have a known value
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (i_issue_en && is_store) begin
            mem[addr] <= i_src1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= i_issue_en;
        end
    end

    // A store reports the data it wrote, a load the word it read
    always_ff @(posedge clk) begin
        if (i_issue_en) begin
            o_cdb_data <= is_store ? i_src1 : mem[addr];
            o_cdb_tag  <= i_tag;
        end
    end

endmodule

//--- logic/issue_backend.sv
`timescale 1ns/1ps

module issue_backend import issue_pkg::*; #(
    parameter int       DATA_WIDTH = 32,
    parameter int       TAG_WIDTH  = 5,
    parameter int       NUM_RS     = 3,
    parameter int       RS_DEPTH   = 4,
    parameter fu_type_t RS_FU_TYPES [NUM_RS] = '{FU_IEU, FU_IEU, FU_LSU}
)(
    input  logic                  clk,
    input  logic                  i_reset,

    input  logic                  i_dispatch_en,
    input  op_t                   i_dispatch_op,
    input  logic [TAG_WIDTH-1:0]  i_dispatch_dst_tag,
    input  logic                  i_src_rdy  [0:N_SRC-1],
    input  logic [DATA_WIDTH-1:0] i_src_data [0:N_SRC-1],
    input  logic [TAG_WIDTH-1:0]  i_src_tag  [0:N_SRC-1],
    output logic                  o_dispatch_stall,

    output logic                  o_cdb_en   [0:NUM_RS-1],
    output logic [DATA_WIDTH-1:0] o_cdb_data [0:NUM_RS-1],
    output logic [TAG_WIDTH-1:0]  o_cdb_tag  [0:NUM_RS-1]
);

    logic [NUM_RS-1:0]     rs_reserve_en;
    logic [NUM_RS-1:0]     rs_full;
    logic                  sw_src_rdy  [0:N_SRC-1];
    logic [DATA_WIDTH-1:0] sw_src_data [0:N_SRC-1];
    logic [TAG_WIDTH-1:0]  sw_src_tag  [0:N_SRC-1];

    logic                  issue_en   [0:NUM_RS-1];
    op_t                   issue_op   [0:NUM_RS-1];
    logic [DATA_WIDTH-1:0] issue_src0 [0:NUM_RS-1];
    logic [DATA_WIDTH-1:0] issue_src1 [0:NUM_RS-1];
    logic [TAG_WIDTH-1:0]  issue_tag  [0:NUM_RS-1];

    rs_switch #(
        .DATA_WIDTH  (DATA_WIDTH),
        .TAG_WIDTH   (TAG_WIDTH),
        .NUM_RS      (NUM_RS),
        .RS_FU_TYPES (RS_FU_TYPES)
    ) u_rs_switch (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_cdb_en        (o_cdb_en),
        .i_cdb_data      (o_cdb_data),
        .i_cdb_tag       (o_cdb_tag),
        .i_reserve_en    (i_dispatch_en),
        .i_reserve_op    (i_dispatch_op),
        .i_src_rdy       (i_src_rdy),
        .i_src_data      (i_src_data),
        .i_src_tag       (i_src_tag),
        .i_rs_stall      (rs_full),
        .o_rs_reserve_en (rs_reserve_en),
        .o_src_rdy       (sw_src_rdy),
        .o_src_data      (sw_src_data),
        .o_src_tag       (sw_src_tag),
        .o_stall         (o_dispatch_stall)
    );

    // Each station feeds one unit, and that unit owns the CDB lane with the same index
    for (genvar i = 0; i < NUM_RS; i++) begin : g_lane
        rsv_station #(
            .DATA_WIDTH (DATA_WIDTH),
            .TAG_WIDTH  (TAG_WIDTH),
            .NUM_RS     (NUM_RS),
            .RS_DEPTH   (RS_DEPTH)
        ) u_rsv_station (
            .clk          (clk),
            .i_reset      (i_reset),
            .i_cdb_en     (o_cdb_en),
            .i_cdb_data   (o_cdb_data),
            .i_cdb_tag    (o_cdb_tag),
            .i_reserve_en (rs_reserve_en[i]),
            .i_op         (i_dispatch_op),
            .i_dst_tag    (i_dispatch_dst_tag),
            .i_src_rdy    (sw_src_rdy),
            .i_src_data   (sw_src_data),
            .i_src_tag    (sw_src_tag),
            .o_full       (rs_full[i]),
            .o_issue_en   (issue_en[i]),
            .o_issue_op   (issue_op[i]),
            .o_issue_src0 (issue_src0[i]),
            .o_issue_src1 (issue_src1[i]),
            .o_issue_tag  (issue_tag[i])
        );

        if (RS_FU_TYPES[i] == FU_LSU) begin : g_lsu
            lsu #(
                .DATA_WIDTH (DATA_WIDTH),
                .TAG_WIDTH  (TAG_WIDTH)
            ) u_lsu (
                .clk        (clk),
                .i_reset    (i_reset),
                .i_issue_en (issue_en[i]),
                .i_op       (issue_op[i]),
                .i_src0     (issue_src0[i]),
                .i_src1     (issue_src1[i]),
                .i_tag      (issue_tag[i]),
                .o_cdb_en   (o_cdb_en[i]),
                .o_cdb_data (o_cdb_data[i]),
                .o_cdb_tag  (o_cdb_tag[i])
            );
        end else begin : g_ieu
            ieu #(
                .DATA_WIDTH (DATA_WIDTH),
                .TAG_WIDTH  (TAG_WIDTH)
            ) u_ieu (
                .clk        (clk),
                .i_reset    (i_reset),
                .i_issue_en (issue_en[i]),
                .i_op       (issue_op[i]),
                .i_src0     (issue_src0[i]),
                .i_src1     (issue_src1[i]),
                .i_tag      (issue_tag[i]),
                .o_cdb_en   (o_cdb_en[i]),
                .o_cdb_data (o_cdb_data[i]),
                .o_cdb_tag  (o_cdb_tag[i])
            );
        end
    end

endmodule

//--- test/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int err_data  = 0;
int err_tag   = 0;
int err_flag  = 0;
int err_other = 0;

task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] exp,
                          input logic [DATA_WIDTH-1:0] act);
    if (act !== exp) begin
        $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
        err_data++;
    end
endtask

task automatic check_tag(input string name, input logic [TAG_WIDTH-1:0] exp,
                         input logic [TAG_WIDTH-1:0] act);
    if (act !== exp) begin
        $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
        err_tag++;
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s expected 0x%h actual 0x%h", name, exp, act);
        err_flag++;
    end
endtask

task automatic report_failure(input string msg);
    $display("%s", msg);
    err_other++;
endtask

`endif

//--- test/tb_issue_backend.sv
`timescale 1ns/1ps

module tb_issue_backend
    import issue_pkg::*;
();

    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH  = 5;
    localparam int NUM_RS     = 3;
    localparam int RS_DEPTH   = 4;
    localparam int MEM_WORDS  = 16;
    localparam int TIMEOUT    = 50;

    `include "tb_checks.svh"

    logic                  clk = 1'b0;
    logic                  i_reset;
    logic                  i_dispatch_en;
    op_t                   i_dispatch_op;
    logic [TAG_WIDTH-1:0]  i_dispatch_dst_tag;
    logic                  i_src_rdy  [0:N_SRC-1];
    logic [DATA_WIDTH-1:0] i_src_data [0:N_SRC-1];
    logic [TAG_WIDTH-1:0]  i_src_tag  [0:N_SRC-1];
    logic                  o_dispatch_stall;
    logic                  o_cdb_en   [0:NUM_RS-1];
    logic [DATA_WIDTH-1:0] o_cdb_data [0:NUM_RS-1];
    logic [TAG_WIDTH-1:0]  o_cdb_tag  [0:NUM_RS-1];

    // Reference model state
    logic [DATA_WIDTH-1:0] model_mem [0:MEM_WORDS-1];
    logic [DATA_WIDTH-1:0] tag_val   [0:2**TAG_WIDTH-1];
    logic [3:0]            st_addr;

    // Every CDB broadcast seen so far, indexed by its tag
    bit                    seen_valid [0:2**TAG_WIDTH-1];
    logic [DATA_WIDTH-1:0] seen_data  [0:2**TAG_WIDTH-1];
    int                    seen_lane  [0:2**TAG_WIDTH-1];
    int                    seen_cyc   [0:2**TAG_WIDTH-1];
    int                    cyc = 0;

    issue_backend #(
        .DATA_WIDTH (DATA_WIDTH),
        .TAG_WIDTH  (TAG_WIDTH),
        .NUM_RS     (NUM_RS),
        .RS_DEPTH   (RS_DEPTH)
    ) u_issue_backend (
        .clk                (clk),
        .i_reset            (i_reset),
        .i_dispatch_en      (i_dispatch_en),
        .i_dispatch_op      (i_dispatch_op),
        .i_dispatch_dst_tag (i_dispatch_dst_tag),
        .i_src_rdy          (i_src_rdy),
        .i_src_data         (i_src_data),
        .i_src_tag          (i_src_tag),
        .o_dispatch_stall   (o_dispatch_stall),
        .o_cdb_en           (o_cdb_en),
        .o_cdb_data         (o_cdb_data),
        .o_cdb_tag          (o_cdb_tag)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Lanes change on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        for (int c = 0; c < NUM_RS; c++) begin
            if (o_cdb_en[c] === 1'b1) begin
                seen_valid[o_cdb_tag[c]] = 1'b1;
                seen_data[o_cdb_tag[c]]  = o_cdb_data[c];
                seen_lane[o_cdb_tag[c]]  = c;
                seen_cyc[o_cdb_tag[c]]   = cyc;
            end
        end
    end

    function automatic logic [DATA_WIDTH-1:0] alu_model(input op_t op,
            input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            default: return '0;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic drive_op(input op_t op, input logic [TAG_WIDTH-1:0] dst,
            input logic r0, input logic [DATA_WIDTH-1:0] d0, input logic [TAG_WIDTH-1:0] t0,
            input logic r1, input logic [DATA_WIDTH-1:0] d1, input logic [TAG_WIDTH-1:0] t1);
        seen_valid[dst]    = 1'b0;
        i_dispatch_en      = 1'b1;
        i_dispatch_op      = op;
        i_dispatch_dst_tag = dst;
        i_src_rdy[0]       = r0;
        i_src_data[0]      = d0;
        i_src_tag[0]       = t0;
        i_src_rdy[1]       = r1;
        i_src_data[1]      = d1;
        i_src_tag[1]       = t1;
    endtask

    // Holds the driven operation until an edge with no stall accepts it
    task automatic wait_accept(output int acc_cyc, output int stalls);
        stalls = 0;
        #1;
        while (o_dispatch_stall && stalls < TIMEOUT) begin
            @(posedge clk);
            #1.5;
            stalls++;
        end
        if (o_dispatch_stall) begin
            report_failure("Dispatch stayed stalled past the timeout");
        end
        next_cycle();
        acc_cyc       = cyc;
        i_dispatch_en = 1'b0;
    endtask

    task automatic alu_ready(input op_t op, input logic [TAG_WIDTH-1:0] dst,
            input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b, output int acc_cyc);
        int stalls;
        drive_op(op, dst, 1'b1, a, '0, 1'b1, b, '0);
        wait_accept(acc_cyc, stalls);
        tag_val[dst] = alu_model(op, a, b);
    endtask

    // A negative latency or lane means that it is not checked
    task automatic expect_result(input logic [TAG_WIDTH-1:0] tag,
            input logic [DATA_WIDTH-1:0] exp, input int acc_cyc, input int lat, input int lane);
        int waited;
        waited = 0;
        while (!seen_valid[tag] && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (!seen_valid[tag]) begin
            report_failure($sformatf("No CDB result arrived for tag %0d", tag));
        end else begin
            check_data($sformatf("o_cdb_data (tag %0d)", tag), exp, seen_data[tag]);
            if (lat >= 0 && seen_cyc[tag] - acc_cyc != lat) begin
                report_failure($sformatf("Tag %0d took %0d cycles instead of %0d",
                    tag, seen_cyc[tag] - acc_cyc, lat));
            end
            if (lane >= 0 && seen_lane[tag] != lane) begin
                report_failure($sformatf("Tag %0d came on lane %0d instead of lane %0d",
                    tag, seen_lane[tag], lane));
            end
        end
    endtask

    task automatic test_reset();
        next_cycle();
        for (int c = 0; c < NUM_RS; c++) begin
            check_flag($sformatf("o_cdb_en[%0d]", c), 1'b0, o_cdb_en[c]);
        end
        check_flag("o_dispatch_stall", 1'b0, o_dispatch_stall);
    endtask

    task automatic test_alu_rotation();
        int acc_a;
        int acc_b;
        alu_ready(OP_ADD, 5'd1, $urandom(), $urandom(), acc_a);
        alu_ready(OP_SUB, 5'd2, $urandom(), $urandom(), acc_b);
        // The first result goes out on lane 0, the second one a cycle later on lane 1
        next_cycle();
        check_flag("o_cdb_en[0]", 1'b1, o_cdb_en[0]);
        check_tag("o_cdb_tag[0]", 5'd1, o_cdb_tag[0]);
        check_data("o_cdb_data[0]", tag_val[1], o_cdb_data[0]);
        next_cycle();
        check_flag("o_cdb_en[1]", 1'b1, o_cdb_en[1]);
        check_tag("o_cdb_tag[1]", 5'd2, o_cdb_tag[1]);
        check_data("o_cdb_data[1]", tag_val[2], o_cdb_data[1]);
        expect_result(5'd1, tag_val[1], acc_a, 2, 0);
        expect_result(5'd2, tag_val[2], acc_b, 2, 1);
        alu_ready(OP_AND, 5'd3, $urandom(), $urandom(), acc_a);
        expect_result(5'd3, tag_val[3], acc_a, 2, -1);
        alu_ready(OP_XOR, 5'd4, $urandom(), $urandom(), acc_a);
        expect_result(5'd4, tag_val[4], acc_a, 2, -1);
    endtask

    task automatic test_store_load();
        int                    acc;
        int                    stalls;
        logic [DATA_WIDTH-1:0] val;
        st_addr = $urandom();
        val     = $urandom();
        drive_op(OP_ST, 5'd5, 1'b1, DATA_WIDTH'(st_addr), '0, 1'b1, val, '0);
        wait_accept(acc, stalls);
        model_mem[st_addr] = val;
        expect_result(5'd5, val, acc, 2, 2);
        // Only the low address bits select the word
        drive_op(OP_LD, 5'd6, 1'b1, ($urandom() & 32'hFFFF_FFF0) | DATA_WIDTH'(st_addr), '0,
                 1'b1, '0, '0);
        wait_accept(acc, stalls);
        expect_result(5'd6, model_mem[st_addr], acc, 2, 2);
        drive_op(OP_LD, 5'd6, 1'b1, DATA_WIDTH'(st_addr + 4'd1), '0, 1'b1, '0, '0);
        wait_accept(acc, stalls);
        expect_result(5'd6, model_mem[st_addr + 4'd1], acc, 2, 2);
    endtask

    task automatic test_dependencies();
        int                    acc_c;
        int                    acc_p;
        int                    stalls;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] c;
        b = $urandom();
        c = $urandom();
        // The consumer waits in its station until tag 7 is broadcast
        drive_op(OP_ADD, 5'd8, 1'b0, '0, 5'd7, 1'b1, b, '0);
        wait_accept(acc_c, stalls);
        alu_ready(OP_XOR, 5'd7, $urandom(), $urandom(), acc_p);
        tag_val[8] = alu_model(OP_ADD, tag_val[7], b);
        expect_result(5'd7, tag_val[7], acc_p, 2, -1);
        expect_result(5'd8, tag_val[8], acc_c, -1, -1);
        // This consumer enqueues while its producer is on the CDB
        alu_ready(OP_SUB, 5'd9, $urandom(), $urandom(), acc_p);
        next_cycle();
        next_cycle();
        drive_op(OP_AND, 5'd10, 1'b1, c, '0, 1'b0, '0, 5'd9);
        wait_accept(acc_c, stalls);
        tag_val[10] = alu_model(OP_AND, c, tag_val[9]);
        expect_result(5'd9, tag_val[9], acc_p, 2, -1);
        if (seen_cyc[9] != acc_c - 1) begin
            report_failure("Tag 10 was not accepted while tag 9 was on the CDB");
        end
        expect_result(5'd10, tag_val[10], acc_c, 2, -1);
    endtask

    task automatic test_stall_recovery();
        int acc;
        int stalls;
        for (int k = 0; k < RS_DEPTH; k++) begin
            drive_op(OP_LD, TAG_WIDTH'(11 + k), 1'b0, '0, 5'd31, 1'b1, '0, '0);
            wait_accept(acc, stalls);
        end
        drive_op(OP_LD, 5'd15, 1'b0, '0, 5'd31, 1'b1, '0, '0);
        #1;
        check_flag("o_dispatch_stall", 1'b1, o_dispatch_stall);
        next_cycle();
        i_dispatch_en = 1'b0;
        alu_ready(OP_ADD, 5'd16, $urandom(), $urandom(), acc);
        expect_result(5'd16, tag_val[16], acc, 2, -1);
        // Tag 31 becomes the address that the waiting loads read
        alu_ready(OP_AND, 5'd31, ($urandom() & 32'hFFFF_FFF0) | DATA_WIDTH'(st_addr),
                  32'h0000_000F, acc);
        expect_result(5'd31, tag_val[31], acc, 2, -1);
        for (int k = 0; k < RS_DEPTH; k++) begin
            expect_result(TAG_WIDTH'(11 + k), model_mem[tag_val[31][3:0]], 0, -1, 2);
        end
        if (seen_valid[15]) begin
            report_failure("The withdrawn load with tag 15 produced a CDB result");
        end
        drive_op(OP_LD, 5'd17, 1'b1, DATA_WIDTH'(st_addr), '0, 1'b1, '0, '0);
        wait_accept(acc, stalls);
        if (stalls != 0) begin
            report_failure("A new load stalled after the LSU station drained");
        end
        expect_result(5'd17, model_mem[st_addr], acc, 2, 2);
    endtask

    initial begin
        void'($urandom(26590));
        i_reset            = 1'b1;
        i_dispatch_en      = 1'b0;
        i_dispatch_op      = OP_ADD;
        i_dispatch_dst_tag = '0;
        for (int s = 0; s < N_SRC; s++) begin
            i_src_rdy[s]  = 1'b0;
            i_src_data[s] = '0;
            i_src_tag[s]  = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end
        repeat (2) @(posedge clk);
        #0.5;
        i_reset = 1'b0;

        test_reset();
        test_alu_rotation();
        test_store_load();
        test_dependencies();
        test_stall_recovery();

        $display("Errors: data %0d, tag %0d, flag %0d, other %0d",
                 err_data, err_tag, err_flag, err_other);
        if (err_data + err_tag + err_flag + err_other == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+test
logic/issue_pkg.sv
logic/rr_picker.sv
logic/rs_switch.sv
logic/rsv_station.sv
logic/ieu.sv
logic/lsu.sv
logic/issue_backend.sv
test/tb_issue_backend.sv
